/* dv/link_vectors.txt */
# columns in hex: we burst_len word_addr sel d0 d1 d2 d3 d4 d5 d6 d7
# writes carry the data to send, reads carry the expected read words
1 1 000005 3 1234 0000 0000 0000 0000 0000 0000 0000
0 1 000005 3 1234 0000 0000 0000 0000 0000 0000 0000
1 4 000010 3 a001 a002 a003 a004 0000 0000 0000 0000
0 4 000010 3 a001 a002 a003 a004 0000 0000 0000 0000
1 8 000020 3 b001 b002 b003 b004 b005 b006 b007 b008
0 8 000020 3 b001 b002 b003 b004 b005 b006 b007 b008
# byte selects, high byte then low byte
1 1 000005 2 abcd 0000 0000 0000 0000 0000 0000 0000
0 1 000005 3 ab34 0000 0000 0000 0000 0000 0000 0000
1 1 000011 1 5566 0000 0000 0000 0000 0000 0000 0000
0 4 000010 3 a001 a066 a003 a004 0000 0000 0000 0000
# bursts running past word 63
1 4 00003e 3 c001 c002 c003 c004 0000 0000 0000 0000
0 4 00003e 3 c001 c002 0000 0000 0000 0000 0000 0000
1 8 00003c 1 d011 d022 d033 d044 d055 d066 d077 d088
0 8 00003c 3 0011 0022 c033 c044 0000 0000 0000 0000
# out of range, the last one shares index bits with word 5
0 1 000040 3 0000 0000 0000 0000 0000 0000 0000 0000
1 1 012345 3 7777 0000 0000 0000 0000 0000 0000 0000
0 1 012345 3 0000 0000 0000 0000 0000 0000 0000 0000
0 1 000005 3 ab34 0000 0000 0000 0000 0000 0000 0000
0 8 000020 3 b001 b002 b003 b004 b005 b006 b007 b008

/* vlog.f */
design/link_pkg.sv
design/wb_pkg.sv
design/wb_compressor.sv
design/link_decoder.sv
design/link_target.sv
design/link_responder.sv
design/link_bridge_top.sv
dv/tb_link_bridge.sv

/* run_sim.sh */
#!/bin/sh
# compile the bridge and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_link_bridge -f vlog.f -o sim_link_bridge
./obj_dir/sim_link_bridge

/* dv/tb_link_bridge.sv */
`timescale 1ns/10ps

module tb_link_bridge;

    localparam int MODEL_DEPTH = 64;

    // one line of the vector file
    typedef struct packed {
        logic we;
        logic [3:0] len;
        wb_pkg::wb_adr_t adr;
        logic [1:0] sel;
        logic [7:0][15:0] dat;  // write words, or the expected read words
    } vec_t;

    logic i_clk = 1'b0;
    logic i_rst;
    wb_pkg::wb_req_t wb_req;
    wb_pkg::wb_dat_t wb_dat;
    logic wb_ack;
    logic wb_err;
    logic link_dir;

    vec_t vecs[$];
    logic [15:0] model_mem [MODEL_DEPTH];
    int cycles = 0;
    int cycle_limit = 1000000;  // tightened once the vectors are loaded

    link_bridge_top dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .wb_req_i   (wb_req),
        .wb_dat_o   (wb_dat),
        .wb_ack_o   (wb_ack),
        .wb_err_o   (wb_err),
        .link_dir_o (link_dir)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the vectors did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        int i;
        string line;
        logic [31:0] f [12];
        vec_t v;
        fd = $fopen("dv/link_vectors.txt", "r");
        if (fd == 0) begin
            $display("the vector file dv/link_vectors.txt could not be opened");
            $display("Something failed");
            $fatal(1);
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5],
                        f[6], f[7], f[8], f[9], f[10], f[11]);
            if (n != 12 || !(f[1] == 1 || f[1] == 4 || f[1] == 8)) begin
                $display("a line of the vector file is malformed: %s", line);
                $display("Something failed");
                $fatal(1);
            end
            v.we = f[0][0];
            v.len = f[1][3:0];
            v.adr = f[2][23:0];
            v.sel = f[3][1:0];
            for (i = 0; i < 8; i++) begin
                v.dat[i] = f[4 + i][15:0];
            end
            vecs.push_back(v);
        end
        $fclose(fd);
    endtask

    // ----------------------------------------
    // one Wishbone cycle, checked beat by beat
    // ----------------------------------------
    task automatic run_cycle(input vec_t v);
        int b;
        int n;
        int idx;
        logic exp_err;
        n = int'(v.len);
        @(negedge i_clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = v.we;
        wb_req.sel = v.sel;
        wb_req.adr = v.adr;
        wb_req.dat = v.dat[0];
        wb_req.burst4 = (n == 4);
        wb_req.burst8 = (n == 8);
        for (b = 0; b < n; b++) begin
            @(negedge i_clk);
            while (!wb_ack && !wb_err) begin
                @(negedge i_clk);
            end
            idx = int'(v.adr) + b;
            exp_err = (idx >= MODEL_DEPTH);  // beats past the memory end fail
            check_value("wb_ack_o and wb_err_o together", 32'(wb_ack & wb_err), 32'd0);
            check_value("wb_err_o", 32'(wb_err), 32'(exp_err));
            check_value("wb_ack_o", 32'(wb_ack), 32'(!exp_err));
            check_value("link_dir_o", 32'(link_dir), 32'(!v.we && b != n - 1));
            if (v.we) begin
                if (!exp_err) begin
                    if (v.sel[1]) begin
                        model_mem[idx][15:8] = v.dat[b][15:8];
                    end
                    if (v.sel[0]) begin
                        model_mem[idx][7:0] = v.dat[b][7:0];
                    end
                end
            end else begin
                check_value("wb_dat_o", 32'(wb_dat), 32'(v.dat[b]));
                if (exp_err) begin
                    check_value("wb_dat_o against model", 32'(wb_dat), 32'd0);
                end else begin
                    check_value("wb_dat_o against model", 32'(wb_dat), 32'(model_mem[idx]));
                end
            end
            if (b == n - 1) begin
                wb_req.cyc = 1'b0;
                wb_req.stb = 1'b0;
            end else if (v.we) begin
                wb_req.stb = 1'b0;  // write bursts re-strobe each word
                @(negedge i_clk);
                wb_req.stb = 1'b1;
                wb_req.dat = v.dat[b + 1];
            end
        end
        // no extra beat may follow, and the link turns back to the near end
        repeat (2) begin
            @(negedge i_clk);
            check_value("wb_ack_o after cycle", 32'(wb_ack), 32'd0);
            check_value("wb_err_o after cycle", 32'(wb_err), 32'd0);
            check_value("link_dir_o after cycle", 32'(link_dir), 32'd0);
        end
    endtask

    initial begin
        i_rst = 1'b1;
        wb_req = '0;
        for (int i = 0; i < MODEL_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        load_vectors();
        cycle_limit = 40 * vecs.size() + 100;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        foreach (vecs[k]) begin
            run_cycle(vecs[k]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

/* design/link_bridge_top.sv */
`timescale 1ns/10ps

module link_bridge_top (
    input  logic            i_clk,
    input  logic            i_rst,
    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_dat_t wb_dat_o,
    output logic            wb_ack_o,
    output logic            wb_err_o,
    output logic            link_dir_o
);

    // ----------------------------------------
    // link wires, near end to far end
    // ----------------------------------------
    link_pkg::link_word_t cw_word;
    logic cw_req;
    logic cw_dir;

    link_pkg::link_word_t rw_word;
    logic rw_ack;
    logic rw_err;

    // far end internals
    link_pkg::link_cmd_t cmd;
    logic cmd_stb;
    link_pkg::link_word_t beat_word;
    logic beat_stb;
    link_pkg::link_result_t res;
    logic res_stb;

    assign link_dir_o = cw_dir;  // the far end does not use the direction flag

    wb_compressor u_compressor (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .wb_req_i  (wb_req_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .cw_word_o (cw_word),
        .cw_req_o  (cw_req),
        .cw_dir_o  (cw_dir),
        .rw_word_i (rw_word),
        .rw_ack_i  (rw_ack),
        .rw_err_i  (rw_err)
    );

    link_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .cw_word_i   (cw_word),
        .cw_req_i    (cw_req),
        .cmd_o       (cmd),
        .cmd_stb_o   (cmd_stb),
        .beat_word_o (beat_word),
        .beat_stb_o  (beat_stb)
    );

    link_target u_target (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .cmd_i       (cmd),
        .cmd_stb_i   (cmd_stb),
        .beat_word_i (beat_word),
        .beat_stb_i  (beat_stb),
        .res_o       (res),
        .res_stb_o   (res_stb)
    );

    link_responder u_responder (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .cmd_stb_i (cmd_stb),
        .res_i     (res),
        .res_stb_i (res_stb),
        .rw_word_o (rw_word),
        .rw_ack_o  (rw_ack),
        .rw_err_o  (rw_err)
    );

endmodule

/* design/link_responder.sv */
`timescale 1ns/10ps

module link_responder (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   cmd_stb_i,
    input  link_pkg::link_result_t res_i,
    input  logic                   res_stb_i,
    output link_pkg::link_word_t   rw_word_o,
    output logic                   rw_ack_o,
    output logic                   rw_err_o
);

    logic res_ok;
    logic res_err;

    assign res_ok = res_stb_i & res_i.ok;
    assign res_err = res_stb_i & res_i.err;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rw_ack_o <= 1'b0;
            rw_err_o <= 1'b0;
        end else begin
            rw_ack_o <= cmd_stb_i | res_ok;  // header ack shares the ack line
            rw_err_o <= res_err;
        end
    end

    // return word is zero outside a result pulse, including the header ack
    always_ff @(posedge i_clk) begin
        rw_word_o <= res_stb_i ? res_i.rdata : '0;
    end

endmodule

/* design/link_target.sv */
`timescale 1ns/10ps

module link_target (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  link_pkg::link_cmd_t    cmd_i,
    input  logic                   cmd_stb_i,
    input  link_pkg::link_word_t   beat_word_i,
    input  logic                   beat_stb_i,
    output link_pkg::link_result_t res_o,
    output logic                   res_stb_o
);

    link_pkg::link_word_t mem [link_pkg::MEM_DEPTH];
    link_pkg::link_cmd_t cmd_q;
    link_pkg::beat_cnt_t cnt;
    logic rd_run;
    logic [link_pkg::ADR_W:0] beat_adr;  // one extra bit so a high start cannot wrap
    logic [link_pkg::MEM_AW-1:0] idx;
    logic in_range;
    logic wr_en;

    assign beat_adr = {1'b0, cmd_q.adr} + (link_pkg::ADR_W + 1)'(cnt);
    assign in_range = beat_adr < (link_pkg::ADR_W + 1)'(link_pkg::MEM_DEPTH);
    assign idx = beat_adr[link_pkg::MEM_AW-1:0];
    assign wr_en = beat_stb_i & in_range;

    // ----------------------------------------
    // beat sequencing and results
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cmd_q <= '0;
            cnt <= '0;
            rd_run <= 1'b0;
            res_stb_o <= 1'b0;
        end else begin
            res_stb_o <= 1'b0;
            if (cmd_stb_i) begin
                cmd_q <= cmd_i;
                cnt <= '0;
                rd_run <= ~cmd_i.we;  // first read beat follows on the next cycle
            end else if (rd_run) begin
                res_o.ok <= in_range;
                res_o.err <= ~in_range;
                res_o.rdata <= in_range ? mem[idx] : '0;
                res_stb_o <= 1'b1;
                cnt <= cnt + 1'b1;
                if (cnt == cmd_q.last) begin
                    rd_run <= 1'b0;
                end
            end else if (beat_stb_i) begin
                res_o.ok <= in_range;
                res_o.err <= ~in_range;
                res_o.rdata <= '0;
                res_stb_o <= 1'b1;
                cnt <= cnt + 1'b1;
            end
        end
    end

    // sel[1] is the high byte, sel[0] the low byte
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < link_pkg::MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            if (cmd_q.sel[1]) begin
                mem[idx][15:8] <= beat_word_i[15:8];
            end
            if (cmd_q.sel[0]) begin
                mem[idx][7:0] <= beat_word_i[7:0];
            end
        end
    end

endmodule

/* design/link_decoder.sv */
`timescale 1ns/10ps

module link_decoder (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  link_pkg::link_word_t cw_word_i,
    input  logic                 cw_req_i,
    output link_pkg::link_cmd_t  cmd_o,
    output logic                 cmd_stb_o,
    output link_pkg::link_word_t beat_word_o,
    output logic                 beat_stb_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR1,
        ST_WDATA
    } state_e;

    state_e state;
    link_pkg::link_hdr0_t hdr_in;
    link_pkg::link_hdr0_t hdr_q;
    link_pkg::beat_cnt_t cnt;

    assign hdr_in = link_pkg::link_hdr0_t'(cw_word_i);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
            cmd_stb_o <= 1'b0;
            beat_stb_o <= 1'b0;
            cnt <= '0;
        end else begin
            cmd_stb_o <= 1'b0;
            beat_stb_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cw_req_i && hdr_in.marker == link_pkg::HDR_MARKER) begin
                        hdr_q <= hdr_in;
                        state <= ST_HDR1;
                    end
                end
                ST_HDR1: begin
                    // word 1 arrives unstrobed in the cycle after word 0
                    cmd_o.adr <= {hdr_q.adr_hi, cw_word_i};
                    cmd_o.we <= hdr_q.we;
                    cmd_o.sel <= hdr_q.sel;
                    cmd_o.last <= link_pkg::cyc_last(hdr_q.cyc);
                    cmd_stb_o <= 1'b1;
                    cnt <= '0;
                    state <= hdr_q.we ? ST_WDATA : ST_IDLE;  // reads are paced by the target
                end
                ST_WDATA: begin
                    if (cw_req_i) begin
                        beat_word_o <= cw_word_i;
                        beat_stb_o <= 1'b1;
                        cnt <= cnt + 1'b1;
                        if (cnt == cmd_o.last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/wb_compressor.sv */
`timescale 1ns/10ps

module wb_compressor (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  wb_pkg::wb_req_t      wb_req_i,
    output wb_pkg::wb_dat_t      wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 wb_err_o,
    output link_pkg::link_word_t cw_word_o,
    output logic                 cw_req_o,
    output logic                 cw_dir_o,
    input  link_pkg::link_word_t rw_word_i,
    input  logic                 rw_ack_i,
    input  logic                 rw_err_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HDR1,
        ST_WACK,
        ST_RDATA,
        ST_WDATA,
        ST_WWAIT,
        ST_WDOWN
    } state_e;

    state_e state;
    link_pkg::cyc_type_e cyc_type;
    link_pkg::link_hdr0_t hdr0;
    link_pkg::beat_cnt_t cnt;
    link_pkg::beat_cnt_t last_q;
    logic we_q;
    logic beat_done;
    logic last_beat;
    logic req_seen;

    // ----------------------------------------
    // header word 0 from the live request
    // ----------------------------------------
    always_comb begin
        if (wb_req_i.burst8) begin
            cyc_type = link_pkg::CYC_BURST8;
        end else if (wb_req_i.burst4) begin
            cyc_type = link_pkg::CYC_BURST4;
        end else begin
            cyc_type = link_pkg::CYC_SINGLE;
        end
        hdr0.adr_hi = wb_req_i.adr[link_pkg::ADR_W-1:link_pkg::LINK_W];
        hdr0.cyc = cyc_type;
        hdr0.we = wb_req_i.we;
        hdr0.sel = wb_req_i.sel;
        hdr0.marker = link_pkg::HDR_MARKER;
    end

    assign req_seen = wb_req_i.cyc & wb_req_i.stb;
    assign beat_done = rw_ack_i | rw_err_i;
    assign last_beat = (cnt == last_q);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
            cw_req_o <= 1'b0;
            cw_dir_o <= 1'b0;
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            we_q <= 1'b0;
            last_q <= '0;
            cnt <= '0;
        end else begin
            cw_req_o <= 1'b0;  // every strobe is a single pulse
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_seen) begin
                        cw_word_o <= link_pkg::link_word_t'(hdr0);
                        cw_req_o <= 1'b1;
                        we_q <= wb_req_i.we;
                        last_q <= link_pkg::cyc_last(cyc_type);
                        cnt <= '0;
                        state <= ST_HDR1;
                    end
                end
                ST_HDR1: begin
                    cw_word_o <= wb_req_i.adr[link_pkg::LINK_W-1:0];  // rides without a strobe
                    state <= ST_WACK;
                end
                ST_WACK: begin
                    if (rw_ack_i) begin
                        if (we_q) begin
                            cw_word_o <= wb_req_i.dat;
                            cw_req_o <= 1'b1;
                            state <= ST_WDATA;
                        end else begin
                            cw_dir_o <= 1'b1;  // far end now drives the return words
                            state <= ST_RDATA;
                        end
                    end
                end
                ST_RDATA: begin
                    if (beat_done) begin
                        wb_ack_o <= rw_ack_i;
                        wb_err_o <= rw_err_i;
                        wb_dat_o <= rw_word_i;
                        cnt <= cnt + 1'b1;
                        if (last_beat) begin
                            cw_dir_o <= 1'b0;
                            state <= ST_WDOWN;
                        end
                    end
                end
                ST_WDATA: begin
                    if (beat_done) begin
                        wb_ack_o <= rw_ack_i;
                        wb_err_o <= rw_err_i;
                        cnt <= cnt + 1'b1;
                        state <= last_beat ? ST_WDOWN : ST_WWAIT;
                    end
                end
                ST_WWAIT: begin
                    // the master re-strobes with the next word once it has seen the ack
                    if (req_seen && !wb_ack_o) begin
                        cw_word_o <= wb_req_i.dat;
                        cw_req_o <= 1'b1;
                        state <= ST_WDATA;
                    end
                end
                ST_WDOWN: begin
                    state <= ST_IDLE;  // lets the master drop cyc before the next sample
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/wb_pkg.sv */
package wb_pkg;

    localparam int WB_ADR_W = 24;
    localparam int WB_DAT_W = 16;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;  // word address
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    // ----------------------------------------
    // master side of a classic cycle
    // ----------------------------------------
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [1:0] sel;
        wb_adr_t adr;
        wb_dat_t dat;
        logic burst4;
        logic burst8;  // wins over burst4 when both are set
    } wb_req_t;

endpackage

/* design/link_pkg.sv */
package link_pkg;

    // ----------------------------------------
    // widths and memory geometry
    // ----------------------------------------
    localparam int LINK_W = 16;
    localparam int ADR_W = 24;
    localparam int MEM_DEPTH = 64;
    localparam int MEM_AW = 6;
    localparam logic HDR_MARKER = 1'b1;  // the lsb of header word 0 marks a header

    typedef logic [LINK_W-1:0] link_word_t;
    typedef logic [ADR_W-1:0] link_adr_t;
    typedef logic [2:0] beat_cnt_t;  // also used as the last-beat index

    typedef enum logic [3:0] {
        CYC_SINGLE = 4'd0,
        CYC_BURST8 = 4'd1,
        CYC_BURST4 = 4'd2
    } cyc_type_e;

    // ----------------------------------------
    // header word 0, msb first
    // ----------------------------------------
    // word 1 of the header carries address bits 15 to 0
    typedef struct packed {
        logic [ADR_W-LINK_W-1:0] adr_hi;
        cyc_type_e cyc;
        logic we;
        logic [1:0] sel;
        logic marker;
    } link_hdr0_t;

    typedef struct packed {
        link_adr_t adr;
        logic we;
        logic [1:0] sel;
        beat_cnt_t last;
    } link_cmd_t;

    typedef struct packed {
        logic ok;
        logic err;
        link_word_t rdata;
    } link_result_t;

    function automatic beat_cnt_t cyc_last(cyc_type_e cyc);
        case (cyc)
            CYC_BURST8: return 3'd7;
            CYC_BURST4: return 3'd3;
            default: return 3'd0;  // unknown types decode as a single beat
        endcase
    endfunction

endpackage
